// File: tb.f
+incdir+include
source/rate_pkg.sv
source/pid.sv
source/angle_error_accum.sv
source/rate_sequencer.sv
source/rate_controller.sv
verification/rate_controller_tb.sv

// File: include/rate_model.svh
`ifndef RATE_MODEL_SVH
`define RATE_MODEL_SVH

// Reference arithmetic of one axis. Expects rate_pkg to be imported where
// this is included. The caller keeps the accumulated error and the previous
// rate error of each axis, both zero after reset.

function automatic logic signed [err_width-1:0] model_error(
	input logic signed [rate_width-1:0] target,
	input logic signed [imu_width-1:0]  imu
);
	return target - (imu >>> imu_scalar);
endfunction

// New accumulated error after one accepted sample.
function automatic logic signed [rate_width-1:0] model_accum(
	input logic signed [rate_width-1:0] acc,
	input logic signed [rate_width-1:0] target,
	input logic signed [imu_width-1:0]  imu
);
	logic signed [err_width:0] sum;
	sum = acc + model_error(target, imu);
	if (sum > angle_limit)
		return angle_limit;
	else if (sum < -angle_limit)
		return -angle_limit;
	return sum[rate_width-1:0];
endfunction

// Clamped PID result. angle_err is the accumulator value after this sample.
function automatic logic signed [rate_width-1:0] model_pid(
	input logic signed [rate_width-1:0] target,
	input logic signed [imu_width-1:0]  imu,
	input logic signed [rate_width-1:0] angle_err,
	input logic signed [err_width-1:0]  prev_err,
	input logic signed [rate_width-1:0] k_p,
	input logic signed [rate_width-1:0] k_i,
	input logic signed [rate_width-1:0] k_d,
	input logic [3:0] p_shift,
	input logic [3:0] i_shift,
	input logic [3:0] d_shift
);
	logic signed [err_width-1:0]    err;
	logic signed [change_width-1:0] change;
	logic signed [term_width-1:0]   p_term;
	logic signed [term_width-1:0]   i_term;
	logic signed [term_width-1:0]   d_term;
	logic signed [sum_width-1:0]    total;
	err = model_error(target, imu);
	change = prev_err - err;
	p_term = (k_p * err) >>> p_shift;
	i_term = (k_i * angle_err) >>> i_shift;
	d_term = (k_d * change) >>> d_shift;
	total = p_term + i_term + d_term;
	if (total < rate_min)
		return rate_min;
	else if (total > rate_max)
		return rate_max;
	return total[rate_width-1:0];
endfunction

`endif

// File: verification/rate_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rate_controller_tb import rate_pkg::*; ();

	`include "rate_model.svh"

	localparam int random_count = 200;
	localparam int clamp_count = 4;
	localparam int windup_count = 16;
	localparam int drop_count = 2;
	localparam int sample_total = random_count + clamp_count + windup_count + drop_count;
	localparam int timeout_cycles = 20 * sample_total + 200;
	localparam int cmd_latency = 8;            // Edges from acceptance to cmd_valid.

	logic        us_clk;
	logic        resetn;
	logic        imu_valid;
	axis_rates_t target_rates;
	imu_rates_t  imu_rates;
	axis_rates_t rate_cmd;
	logic        cmd_valid;
	logic        busy;

	axis_rates_t                 model_acc;    // Accumulated error per axis.
	logic signed [err_width-1:0] prev_err [3]; // Roll, pitch, yaw.
	int error_count;
	int tests_run;
	int tests_failed;
	int cycle_count = 0;

	rate_controller UUT (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.imu_valid    (imu_valid),
		.target_rates (target_rates),
		.imu_rates    (imu_rates),
		.rate_cmd     (rate_cmd),
		.cmd_valid    (cmd_valid),
		.busy         (busy)
	);

	initial begin
		us_clk = 1'b0;
		forever #5 us_clk = ~us_clk;
	end

	always @(posedge us_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Run stopped by the cycle limit after %0d cycles.", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("MISMATCH %s expected %h got %h", name, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR %s", what);
		error_count++;
	endtask

	// Uniform value in the range minus span to plus span.
	function automatic logic signed [15:0] random_value(input int span);
		int r;
		r = int'($urandom % (2 * span + 1)) - span;
		return r[15:0];
	endfunction

	// Advances the model by one accepted sample and gives the expected commands.
	task automatic predict(input axis_rates_t t, input imu_rates_t m,
			output axis_rates_t expected);
		model_acc.roll = model_accum(model_acc.roll, t.roll, m.roll);
		model_acc.pitch = model_accum(model_acc.pitch, t.pitch, m.pitch);
		model_acc.yaw = model_accum(model_acc.yaw, t.yaw, m.yaw);
		expected.roll = model_pid(t.roll, m.roll, model_acc.roll, prev_err[0],
			roll_k_p, roll_k_i, roll_k_d, roll_p_shift, roll_i_shift, roll_d_shift);
		expected.pitch = model_pid(t.pitch, m.pitch, model_acc.pitch, prev_err[1],
			pitch_k_p, pitch_k_i, pitch_k_d, pitch_p_shift, pitch_i_shift, pitch_d_shift);
		expected.yaw = model_pid(t.yaw, m.yaw, model_acc.yaw, prev_err[2],
			yaw_k_p, yaw_k_i, yaw_k_d, yaw_p_shift, yaw_i_shift, yaw_d_shift);
		prev_err[0] = model_error(t.roll, m.roll);
		prev_err[1] = model_error(t.pitch, m.pitch);
		prev_err[2] = model_error(t.yaw, m.yaw);
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(posedge us_clk);
			#1;
		end
	endtask

	// Holds the strobe for one edge and returns 1 ns after that edge.
	task automatic drive_sample(input axis_rates_t t, input imu_rates_t m);
		target_rates = t;
		imu_rates = m;
		imu_valid = 1'b1;
		@(posedge us_clk);
		#1;
		imu_valid = 1'b0;
	endtask

	task automatic wait_cmd(output int edges);
		edges = 0;
		do begin
			@(posedge us_clk);
			#1;
			edges++;
		end while (!cmd_valid && edges < 20);
		if (!cmd_valid)
			report_failure("no cmd_valid within 20 cycles of the sample");
	endtask

	task automatic check_cmd(input axis_rates_t expected);
		if (rate_cmd.roll !== expected.roll)
			report_mismatch("rate_cmd.roll", expected.roll, rate_cmd.roll);
		if (rate_cmd.pitch !== expected.pitch)
			report_mismatch("rate_cmd.pitch", expected.pitch, rate_cmd.pitch);
		if (rate_cmd.yaw !== expected.yaw)
			report_mismatch("rate_cmd.yaw", expected.yaw, rate_cmd.yaw);
	endtask

	task automatic run_sample(input axis_rates_t t, input imu_rates_t m);
		axis_rates_t expected;
		int edges;
		wait_idle();
		predict(t, m, expected);
		drive_sample(t, m);
		wait_cmd(edges);
		if (edges != cmd_latency)
			report_mismatch("cmd_valid latency", 16'(cmd_latency), 16'(edges));
		check_cmd(expected);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed, %0d errors", tests_run, name,
				error_count - errors_before);
		end
	endtask

	initial begin
		axis_rates_t t;
		imu_rates_t  m;
		axis_rates_t expected;
		axis_rates_t prev_cmd;
		logic [2:0]  max_hits;
		logic [2:0]  min_hits;
		int mark;
		int edges;
		int span;
		void'($urandom(25));
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		model_acc = '0;
		for (int a = 0; a < 3; a++)
			prev_err[a] = '0;
		resetn = 1'b0;
		imu_valid = 1'b0;
		target_rates = '0;
		imu_rates = '0;
		repeat (5) @(posedge us_clk);
		#1;
		resetn = 1'b1;

		mark = error_count;
		if (cmd_valid !== 1'b0)
			report_mismatch("cmd_valid", 16'h0, {15'h0, cmd_valid});
		if (busy !== 1'b0)
			report_mismatch("busy", 16'h0, {15'h0, busy});
		check_cmd('0);
		finish_test("reset state", mark);

		mark = error_count;
		for (int i = 0; i < random_count; i++) begin
			span = (($urandom % 8) == 0) ? 30000 : 2000;   // Some samples reach the clamps.
			t.roll = random_value(span);
			t.pitch = random_value(span);
			t.yaw = random_value(span);
			m.roll = random_value(32000);
			m.pitch = random_value(32000);
			m.yaw = random_value(32000);
			run_sample(t, m);
		end
		finish_test("random samples", mark);

		// Two samples of each sign, so the derivative is zero on the repeat.
		mark = error_count;
		max_hits = '0;
		min_hits = '0;
		for (int i = 0; i < clamp_count; i++) begin
			if (i < clamp_count / 2) begin
				t = {16'sh7fff, 16'sh8000, 16'sh7fff};
				m = {16'sh8000, 16'sh7fff, 16'sh8000};
			end else begin
				t = {16'sh8000, 16'sh7fff, 16'sh8000};
				m = {16'sh7fff, 16'sh8000, 16'sh7fff};
			end
			run_sample(t, m);
			max_hits |= {rate_cmd.roll == rate_max, rate_cmd.pitch == rate_max,
				rate_cmd.yaw == rate_max};
			min_hits |= {rate_cmd.roll == rate_min, rate_cmd.pitch == rate_min,
				rate_cmd.yaw == rate_min};
		end
		if (max_hits != 3'b111 || min_hits != 3'b111)
			report_failure("large errors did not drive every axis to both clamp limits");
		finish_test("output clamps", mark);

		mark = error_count;
		prev_cmd = '0;
		for (int i = 0; i < windup_count; i++) begin
			t = {16'sd2000, 16'sd2000, 16'sd2000};
			m = {-16'sd16000, -16'sd16000, -16'sd16000};   // Error of 3000 per sample.
			run_sample(t, m);
			if (i == windup_count - 1 && rate_cmd !== prev_cmd)
				report_failure("rate_cmd still grows with the accumulated error at its bound");
			prev_cmd = rate_cmd;
		end
		if (model_acc.roll != angle_limit || model_acc.pitch != angle_limit
				|| model_acc.yaw != angle_limit)
			report_failure("model accumulator did not reach angle_limit");
		if (UUT.roll_accum.angle_error !== angle_limit)
			report_mismatch("roll_accum.angle_error", angle_limit, UUT.roll_accum.angle_error);
		if (UUT.pitch_accum.angle_error !== angle_limit)
			report_mismatch("pitch_accum.angle_error", angle_limit,
				UUT.pitch_accum.angle_error);
		if (UUT.yaw_accum.angle_error !== angle_limit)
			report_mismatch("yaw_accum.angle_error", angle_limit, UUT.yaw_accum.angle_error);
		finish_test("error windup", mark);

		mark = error_count;
		wait_idle();
		t = {16'sd300, -16'sd250, 16'sd120};
		m = {16'sd1600, -16'sd3200, 16'sd800};
		predict(t, m, expected);
		drive_sample(t, m);
		@(posedge us_clk);
		#1;
		if (!busy)
			report_failure("busy low in the middle of a calculation");
		// The PIDs read the latched sample on the edge after this strobe.
		target_rates = {-16'sd900, 16'sd700, -16'sd500};
		imu_rates = {16'sd4000, -16'sd4000, 16'sd2000};
		imu_valid = 1'b1;                              // This one must be dropped.
		@(posedge us_clk);
		#1;
		imu_valid = 1'b0;
		wait_cmd(edges);
		if (edges + 2 != cmd_latency)
			report_mismatch("cmd_valid latency", 16'(cmd_latency), 16'(edges + 2));
		check_cmd(expected);
		repeat (12) begin
			@(posedge us_clk);
			#1;
			if (cmd_valid)
				report_failure("a second cmd_valid followed a sample sent while busy");
		end
		if (busy)
			report_failure("busy still high after the only result");
		finish_test("sample dropped while busy", mark);

		$display("Tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/rate_controller.sv
`timescale 1ns/1ps
`default_nettype none

// Three-axis body-rate controller.
module rate_controller import rate_pkg::*; (
	input  wire              us_clk,
	input  wire              resetn,
	input  wire              imu_valid,
	input  wire axis_rates_t target_rates,
	input  wire imu_rates_t  imu_rates,
	output wire axis_rates_t rate_cmd,
	output wire              cmd_valid,
	output wire              busy
);

	wire axis_rates_t latched_target;
	wire imu_rates_t  latched_imu;
	wire axis_rates_t angle_error;
	wire axis_flags_t pid_active;
	wire axis_flags_t pid_complete;
	wire              sample_strobe;
	wire              start_flag;
	wire              wait_flag;

	rate_sequencer sequencer (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.imu_valid      (imu_valid),
		.target_rates   (target_rates),
		.imu_rates      (imu_rates),
		.pid_active     (pid_active),
		.pid_complete   (pid_complete),
		.latched_target (latched_target),
		.latched_imu    (latched_imu),
		.sample_strobe  (sample_strobe),
		.start_flag     (start_flag),
		.wait_flag      (wait_flag),
		.cmd_valid      (cmd_valid),
		.busy           (busy)
	);

	// Accumulators work on the latched sample, one strobe per accepted sample.
	angle_error_accum roll_accum (
		.us_clk (us_clk), .resetn (resetn), .sample_strobe (sample_strobe),
		.target_rotation (latched_target.roll), .actual_rotation (latched_imu.roll),
		.angle_error (angle_error.roll)
	);

	angle_error_accum pitch_accum (
		.us_clk (us_clk), .resetn (resetn), .sample_strobe (sample_strobe),
		.target_rotation (latched_target.pitch), .actual_rotation (latched_imu.pitch),
		.angle_error (angle_error.pitch)
	);

	angle_error_accum yaw_accum (
		.us_clk (us_clk), .resetn (resetn), .sample_strobe (sample_strobe),
		.target_rotation (latched_target.yaw), .actual_rotation (latched_imu.yaw),
		.angle_error (angle_error.yaw)
	);

	pid #(
		.k_p (roll_k_p), .k_i (roll_k_i), .k_d (roll_k_d),
		.p_shift (roll_p_shift), .i_shift (roll_i_shift), .d_shift (roll_d_shift)
	) roll_pid (
		.us_clk (us_clk), .resetn (resetn), .start_flag (start_flag), .wait_flag (wait_flag),
		.target_rotation (latched_target.roll), .actual_rotation (latched_imu.roll),
		.angle_error (angle_error.roll), .rate_out (rate_cmd.roll),
		.pid_active (pid_active.roll), .pid_complete (pid_complete.roll)
	);

	pid #(
		.k_p (pitch_k_p), .k_i (pitch_k_i), .k_d (pitch_k_d),
		.p_shift (pitch_p_shift), .i_shift (pitch_i_shift), .d_shift (pitch_d_shift)
	) pitch_pid (
		.us_clk (us_clk), .resetn (resetn), .start_flag (start_flag), .wait_flag (wait_flag),
		.target_rotation (latched_target.pitch), .actual_rotation (latched_imu.pitch),
		.angle_error (angle_error.pitch), .rate_out (rate_cmd.pitch),
		.pid_active (pid_active.pitch), .pid_complete (pid_complete.pitch)
	);

	pid #(
		.k_p (yaw_k_p), .k_i (yaw_k_i), .k_d (yaw_k_d),
		.p_shift (yaw_p_shift), .i_shift (yaw_i_shift), .d_shift (yaw_d_shift)
	) yaw_pid (
		.us_clk (us_clk), .resetn (resetn), .start_flag (start_flag), .wait_flag (wait_flag),
		.target_rotation (latched_target.yaw), .actual_rotation (latched_imu.yaw),
		.angle_error (angle_error.yaw), .rate_out (rate_cmd.yaw),
		.pid_active (pid_active.yaw), .pid_complete (pid_complete.yaw)
	);

endmodule

`default_nettype wire

// File: source/rate_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Accepts one IMU sample at a time and runs the three PIDs on it.
module rate_sequencer import rate_pkg::*; (
	input  wire              us_clk,
	input  wire              resetn,
	input  wire              imu_valid,
	input  wire axis_rates_t target_rates,
	input  wire imu_rates_t  imu_rates,
	input  wire axis_flags_t pid_active,
	input  wire axis_flags_t pid_complete,
	output axis_rates_t      latched_target,
	output imu_rates_t       latched_imu,
	output logic             sample_strobe,
	output logic             start_flag,
	output logic             wait_flag,
	output logic             cmd_valid,
	output logic             busy
);

	seq_state_t state;
	logic       accept;
	logic       all_done;

	assign accept = imu_valid && !busy;   // Strobes during a calculation are dropped.

	// Each PID is finished when it is active and complete at the same time.
	assign all_done = &(pid_active & pid_complete);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= seq_idle;
			sample_strobe <= 1'b0;
			start_flag <= 1'b0;
			wait_flag <= 1'b0;
			cmd_valid <= 1'b0;
			busy <= 1'b0;
		end else begin
			case (state)
				seq_idle: begin
					if (accept) begin
						sample_strobe <= 1'b1;
						busy <= 1'b1;
						state <= seq_start;
					end
				end
				seq_start: begin
					// The accumulators take the strobe on this edge.
					sample_strobe <= 1'b0;
					start_flag <= 1'b1;
					state <= seq_run;
				end
				seq_run: begin
					start_flag <= 1'b0;
					if (all_done) begin
						cmd_valid <= 1'b1;
						wait_flag <= 1'b1;   // Sends the PIDs back to wait.
						state <= seq_done;
					end
				end
				seq_done: begin
					cmd_valid <= 1'b0;
					wait_flag <= 1'b0;
					busy <= 1'b0;
					state <= seq_idle;
				end
				default: begin
					state <= seq_idle;
				end
			endcase
		end
	end

	// Sample registers, held for the whole calculation.
	always_ff @(posedge us_clk) begin
		if (accept) begin
			latched_target <= target_rates;
			latched_imu <= imu_rates;
		end
	end

	no_accept_while_busy: assert property (@(posedge us_clk) disable iff (!resetn)
		(imu_valid && busy) |=> !sample_strobe)
		else $error("IMU sample accepted while busy.");

	// Start delay plus the PID steps fix the latency from start to result.
	result_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		$rose(cmd_valid) |-> $past(start_flag, 7))
		else $error("cmd_valid not seven cycles after start_flag.");

endmodule

`default_nettype wire

// File: source/angle_error_accum.sv
`timescale 1ns/1ps
`default_nettype none

// Running sum of the rate error for one axis. The sum is what the integral
// term of the PID multiplies, so it is held inside a fixed bound to stop
// wind-up while the frame cannot follow the command.
module angle_error_accum import rate_pkg::*; (
	input  wire                          us_clk,
	input  wire                          resetn,
	input  wire                          sample_strobe,
	input  wire signed [rate_width-1:0]  target_rotation,
	input  wire signed [imu_width-1:0]   actual_rotation,
	output logic signed [rate_width-1:0] angle_error
);

	logic signed [err_width-1:0] rate_error;
	logic signed [err_width:0]   next_sum;    // One bit above the error for the carry.
	logic signed [rate_width-1:0] limited_sum;

	// Same error the PID forms in its first step.
	always_comb begin
		rate_error = target_rotation - (actual_rotation >>> imu_scalar);
		next_sum = angle_error + rate_error;
	end

	always_comb begin
		if (next_sum > angle_limit)
			limited_sum = angle_limit;
		else if (next_sum < -angle_limit)
			limited_sum = -angle_limit;
		else
			limited_sum = next_sum[rate_width-1:0];
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			angle_error <= '0;
		else if (sample_strobe)
			angle_error <= limited_sum;   // Only accepted samples count.
	end

	// The sum stays inside the bound at all times.
	accum_in_bound: assert property (@(posedge us_clk) disable iff (!resetn)
		(angle_error <= angle_limit) && (angle_error >= -angle_limit))
		else $error("Accumulated error beyond angle_limit.");

endmodule

`default_nettype wire

// File: source/pid.sv
`timescale 1ns/1ps
`default_nettype none

// Rate PID for one axis. The calculation is spread over four clock cycles so
// that each step holds a single multiply.
module pid import rate_pkg::*; #(
	parameter logic signed [rate_width-1:0] k_p = 16'sd1,
	parameter logic signed [rate_width-1:0] k_i = 16'sd1,
	parameter logic signed [rate_width-1:0] k_d = 16'sd1,
	parameter logic [3:0] p_shift = 4'd0,
	parameter logic [3:0] i_shift = 4'd0,
	parameter logic [3:0] d_shift = 4'd0
) (
	input  wire                          us_clk,
	input  wire                          resetn,
	input  wire                          start_flag,
	input  wire                          wait_flag,
	input  wire signed [rate_width-1:0]  target_rotation,
	input  wire signed [imu_width-1:0]   actual_rotation,
	input  wire signed [rate_width-1:0]  angle_error,
	output logic signed [rate_width-1:0] rate_out,
	output logic                         pid_active,
	output logic                         pid_complete
);

	pid_state_t state;
	pid_state_t next_state;

	logic signed [err_width-1:0]    rotation_error;
	logic signed [err_width-1:0]    prev_rotation_error;
	logic signed [change_width-1:0] error_change;
	logic signed [term_width-1:0]   rotation_proportional;
	logic signed [term_width-1:0]   rotation_integral;
	logic signed [term_width-1:0]   rotation_derivative;
	logic signed [sum_width-1:0]    rotation_total;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= pid_st_wait;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			pid_st_wait:     next_state = start_flag ? pid_st_calc1 : pid_st_wait;
			pid_st_calc1:    next_state = pid_st_calc2;
			pid_st_calc2:    next_state = pid_st_calc3;
			pid_st_calc3:    next_state = pid_st_calc4;
			pid_st_calc4:    next_state = pid_st_complete;
			pid_st_complete: next_state = wait_flag ? pid_st_wait : pid_st_complete;
			default:         next_state = pid_st_wait;
		endcase
	end

	// Status levels, the clamped result and the error history. The error pair
	// starts at zero so the first derivative only sees the first sample.
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			pid_active <= 1'b0;
			pid_complete <= 1'b0;
			rate_out <= '0;
			rotation_error <= '0;
			prev_rotation_error <= '0;
		end else begin
			case (state)
				pid_st_wait: begin
					pid_active <= 1'b0;
					pid_complete <= 1'b1;
				end
				pid_st_calc1: begin
					pid_active <= 1'b1;
					pid_complete <= 1'b0;
					prev_rotation_error <= rotation_error;
					rotation_error <= target_rotation - (actual_rotation >>> imu_scalar);
				end
				pid_st_calc2, pid_st_calc3, pid_st_calc4: begin
					pid_active <= 1'b1;
					pid_complete <= 1'b0;
				end
				pid_st_complete: begin
					pid_active <= 1'b1;
					pid_complete <= 1'b1;
					if (rotation_total < rate_min)
						rate_out <= rate_min;
					else if (rotation_total > rate_max)
						rate_out <= rate_max;
					else
						rate_out <= rotation_total[rate_width-1:0];
				end
				default: begin
					pid_active <= 1'b0;
					pid_complete <= 1'b0;
				end
			endcase
		end
	end

	// Intermediate terms, each valid from the step after it is written.
	always_ff @(posedge us_clk) begin
		case (state)
			pid_st_calc1: begin
				rotation_integral <= (k_i * angle_error) >>> i_shift;
			end
			pid_st_calc2: begin
				rotation_proportional <= (k_p * rotation_error) >>> p_shift;
				error_change <= prev_rotation_error - rotation_error;
			end
			pid_st_calc3: begin
				rotation_derivative <= (k_d * error_change) >>> d_shift;
			end
			pid_st_calc4: begin
				rotation_total <= rotation_proportional + rotation_integral
					+ rotation_derivative;
			end
			default: begin
			end
		endcase
	end

	// A start taken in the wait state gives a finished result five edges later.
	result_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		(state == pid_st_wait && start_flag) |=> ##5 (pid_active && pid_complete))
		else $error("PID result not ready five cycles after start_flag.");

endmodule

`default_nettype wire

// File: source/rate_pkg.sv
`default_nettype none

package rate_pkg;

	// Widths of the rate data path.
	localparam int rate_width = 16;
	localparam int imu_width = 16;
	localparam int err_width = rate_width + 1;        // Target minus scaled IMU rate.
	localparam int change_width = err_width + 1;      // Difference of two errors.
	localparam int term_width = rate_width + change_width;
	localparam int sum_width = term_width + 2;        // Room for three terms.

	// Output clamp of each PID and bound of the accumulated error.
	localparam logic signed [rate_width-1:0] rate_min = 16'sh8000;
	localparam logic signed [rate_width-1:0] rate_max = 16'sh7fff;
	localparam logic signed [rate_width-1:0] angle_limit = 16'sd12000;

	localparam logic [3:0] imu_scalar = 4'd4;         // Raw gyro counts to command units.

	// Roll and pitch share a tune on a symmetric frame.
	localparam logic signed [rate_width-1:0] roll_k_p = 16'sd24;
	localparam logic signed [rate_width-1:0] roll_k_i = 16'sd6;
	localparam logic signed [rate_width-1:0] roll_k_d = 16'sd10;
	localparam logic [3:0] roll_p_shift = 4'd3;
	localparam logic [3:0] roll_i_shift = 4'd3;
	localparam logic [3:0] roll_d_shift = 4'd2;

	localparam logic signed [rate_width-1:0] pitch_k_p = 16'sd24;
	localparam logic signed [rate_width-1:0] pitch_k_i = 16'sd6;
	localparam logic signed [rate_width-1:0] pitch_k_d = 16'sd10;
	localparam logic [3:0] pitch_p_shift = 4'd3;
	localparam logic [3:0] pitch_i_shift = 4'd3;
	localparam logic [3:0] pitch_d_shift = 4'd2;

	// Yaw has more proportional authority and little damping.
	localparam logic signed [rate_width-1:0] yaw_k_p = 16'sd40;
	localparam logic signed [rate_width-1:0] yaw_k_i = 16'sd4;
	localparam logic signed [rate_width-1:0] yaw_k_d = 16'sd4;
	localparam logic [3:0] yaw_p_shift = 4'd3;
	localparam logic [3:0] yaw_i_shift = 4'd3;
	localparam logic [3:0] yaw_d_shift = 4'd2;

	typedef struct packed {
		logic signed [rate_width-1:0] roll;
		logic signed [rate_width-1:0] pitch;
		logic signed [rate_width-1:0] yaw;
	} axis_rates_t;

	typedef struct packed {
		logic signed [imu_width-1:0] roll;
		logic signed [imu_width-1:0] pitch;
		logic signed [imu_width-1:0] yaw;
	} imu_rates_t;

	typedef struct packed {
		logic roll;
		logic pitch;
		logic yaw;
	} axis_flags_t;

	// One-hot PID steps.
	typedef enum logic [5:0] {
		pid_st_wait     = 6'b000001,
		pid_st_calc1    = 6'b000010,
		pid_st_calc2    = 6'b000100,
		pid_st_calc3    = 6'b001000,
		pid_st_calc4    = 6'b010000,
		pid_st_complete = 6'b100000
	} pid_state_t;

	typedef enum logic [3:0] {
		seq_idle  = 4'b0001,
		seq_start = 4'b0010,
		seq_run   = 4'b0100,
		seq_done  = 4'b1000
	} seq_state_t;

endpackage

`default_nettype wire
